// ==== Makefile ====
# Verilator build and run of the memory-controller testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_graphpulse_mem
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail is read back from the log
run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
common/graphpulse_pkg.sv
logic/rr_arbiter.sv
mem_ctrl/vertex_mem_ctrl.sv
mem_ctrl/edge_mem_ctrl.sv
logic/graphpulse_mem_top.sv
bench/tb_graphpulse_mem.sv

// ==== bench/mem_input.txt ====
// vreq vwe vaddr vdata ereq eaddr vresp eresp chk vgnt egnt, one line per cycle
// pe i uses base+i, resp 10 picks stall or tag at random, chk 1 checks the grants
// all four pes requesting, memories always accept
f 5 20 1000 f 0100 1 1 1 0 0
f 5 20 1000 f 0100 1 1 1 1 1
f 5 20 1000 f 0100 1 1 1 2 2
f 5 20 1000 f 0100 1 1 1 4 4
f 5 20 1000 f 0100 1 1 1 8 8
f 5 20 1000 f 0100 1 1 1 1 1
f 5 20 1000 f 0100 1 1 1 2 2
0 0 0 0 0 0 1 1 1 4 4
0 0 0 0 0 0 1 1 1 8 8
0 0 0 0 0 0 1 1 1 1 1
0 0 0 0 0 0 1 1 1 0 0
// single store and edge load held under stall
1 1 a5 beef 4 3ff0 0 0 1 0 0
0 0 0 0 0 0 0 0 1 0 0
0 0 0 0 0 0 0 2 1 0 4
0 0 0 0 0 0 3 0 1 1 0
// single vertex load
2 0 10 1234 0 0 1 0 1 0 0
0 0 0 0 0 0 1 0 1 2 0
0 0 0 0 0 0 0 0 1 0 0
// random stalls on both memories
3 1 30 2000 5 0200 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
c 8 40 2100 a 0300 10 10 0 0 0
1 0 fe 2200 f 3ffe 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
f a 50 2300 0 0 10 10 0 0 0
2 2 60 2400 1 0400 10 10 0 0 0
0 0 0 0 8 0500 10 10 0 0 0
9 9 70 2500 6 0600 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
4 0 80 2600 3 0700 10 10 0 0 0
f f 90 2700 f 0800 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
6 2 a0 2800 9 0900 10 10 0 0 0
1 1 b0 2900 2 0a00 10 10 0 0 0
8 0 c0 2a00 4 0b00 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
5 5 d0 2b00 a 0c00 10 10 0 0 0
a 0 e0 2c00 5 0d00 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
f 3 f0 2d00 f 0e00 10 10 0 0 0
3 0 0c 2e00 c 0f00 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
c c 1c 2f00 3 1000 10 10 0 0 0
7 1 2c 3000 e 1100 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
b 8 3c 3100 7 1200 10 10 0 0 0
0 0 0 0 0 0 10 10 0 0 0
ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff

// ==== bench/tb_graphpulse_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_graphpulse_mem;

    import graphpulse_pkg::*;

    localparam int          CLK_PERIOD    = 100;
    localparam int          RESET_CYCLES  = 10;
    localparam int          NUM_FIELDS    = 11;
    localparam int          MAX_LINES     = 64;
    localparam int          GRANT_TIMEOUT = 64;
    localparam int          DRAIN_LIMIT   = 200;
    localparam int          WATCHDOG_NS   = 100000;
    localparam logic [15:0] LFSR_SEED     = 16'd32;
    localparam logic [15:0] END_MARK      = 16'hffff;
    // response field value meaning stall or accept at random
    localparam logic [15:0] RAND_RESP     = 16'h0010;

    logic                     clock;
    logic                     reset_i;
    vertex_req_t [PE_NUM-1:0] vertex_req;
    edge_req_t [PE_NUM-1:0]   edge_req;
    logic [MEM_TAG_W-1:0]     vertex_resp;
    logic [MEM_TAG_W-1:0]     edge_resp;
    vertex_cmd_t              vertex_cmd;
    edge_cmd_t                edge_cmd;
    logic [PE_NUM-1:0]        vertex_grant;
    logic [PE_NUM-1:0]        edge_grant;

    // stimulus words, NUM_FIELDS per cycle line
    logic [15:0] vec_mem [MAX_LINES * NUM_FIELDS];
    logic [15:0] lfsr_q;

    // pe model, index 0 vertex channel, 1 edge channel
    logic        pend    [2][PE_NUM];
    logic [15:0] pe_addr [2][PE_NUM];
    int          age     [2][PE_NUM];
    logic        pe_we   [PE_NUM];
    logic [15:0] pe_data [PE_NUM];

    // reference model of each issue register
    logic [1:0]        m_cmd   [2];
    logic [15:0]       m_addr  [2];
    logic [63:0]       m_data  [2];
    logic [PE_NUM-1:0] m_owner [2];
    int                m_ptr   [2];

    graphpulse_mem_top i_dut (
        .clock                (clock),
        .reset_i              (reset_i),
        .vertex_req_i         (vertex_req),
        .edge_req_i           (edge_req),
        .vertexmem_response_i (vertex_resp),
        .edgemem_response_i   (edge_resp),
        .vertexmem_cmd_o      (vertex_cmd),
        .edgemem_cmd_o        (edge_cmd),
        .vertex_grant_o       (vertex_grant),
        .edge_grant_o         (edge_grant)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not reach its end in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog");
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    // one lfsr bit decides stall or tag
    task automatic pick_response(input logic [15:0] field, output logic [MEM_TAG_W-1:0] resp);
        if (field == RAND_RESP)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            resp   = lfsr_q[0] ? 4'h7 : 4'h0;
        end
        else
        begin
            resp = field[MEM_TAG_W-1:0];
        end
    endtask

    function automatic int pending_count();
        int n;
        n = 0;
        for (int c = 0; c < 2; c++)
        begin
            for (int i = 0; i < PE_NUM; i++)
            begin
                n += int'(pend[c][i]);
            end
        end
        return n;
    endfunction

    // new requests only for idle pes, busy ones hold theirs
    task automatic add_requests(input int ch, input logic [15:0] mask,
                                input logic [15:0] we_mask, input logic [15:0] addr_base,
                                input logic [15:0] data_base);
        logic [15:0] sum;
        for (int i = 0; i < PE_NUM; i++)
        begin
            if (mask[i] && !pend[ch][i])
            begin
                sum        = addr_base + 16'(i);
                pend[ch][i] = 1'b1;
                age[ch][i]  = 0;
                if (ch == 0)
                begin
                    pe_addr[ch][i] = 16'(sum[VERTEX_ADDR_W-1:0]);
                    pe_we[i]       = we_mask[i];
                    pe_data[i]     = data_base + 16'(i);
                end
                else
                begin
                    pe_addr[ch][i] = 16'(sum[EDGE_ADDR_W-1:0]);
                end
            end
        end
    endtask

    task automatic drive_inputs(input logic [MEM_TAG_W-1:0] vresp,
                                input logic [MEM_TAG_W-1:0] eresp);
        for (int i = 0; i < PE_NUM; i++)
        begin
            vertex_req[i].valid <= pend[0][i];
            vertex_req[i].we    <= pe_we[i];
            vertex_req[i].addr  <= pe_addr[0][i][VERTEX_ADDR_W-1:0];
            vertex_req[i].wdata <= pe_data[i];
            edge_req[i].valid   <= pend[1][i];
            edge_req[i].addr    <= pe_addr[1][i][EDGE_ADDR_W-1:0];
        end
        vertex_resp <= vresp;
        edge_resp   <= eresp;
    endtask

    // payload only matters while a command is out
    task automatic check_outputs();
        check_value("vertexmem_cmd_o.command", 64'(vertex_cmd.command), 64'(m_cmd[0]));
        if (m_cmd[0] != BUS_NONE)
        begin
            check_value("vertexmem_cmd_o.addr", 64'(vertex_cmd.addr), 64'(m_addr[0]));
        end
        if (m_cmd[0] == BUS_STORE)
        begin
            check_value("vertexmem_cmd_o.st_data", vertex_cmd.st_data, m_data[0]);
        end
        check_value("edgemem_cmd_o.command", 64'(edge_cmd.command), 64'(m_cmd[1]));
        if (m_cmd[1] != BUS_NONE)
        begin
            check_value("edgemem_cmd_o.addr", 64'(edge_cmd.addr), 64'(m_addr[1]));
        end
    endtask

    // ----------------------------------------
    // reference model, one cycle per call
    // ----------------------------------------

    task automatic step_channel(input int ch, input logic [MEM_TAG_W-1:0] resp,
                                input logic [PE_NUM-1:0] dut_grant);
        logic [PE_NUM-1:0] exp_grant;
        logic [PE_NUM-1:0] masked;
        logic              load;
        int                win;
        int                idx;
        string             gname;
        string             cname;
        gname = "vertex_grant_o";
        cname = "vertex";
        if (ch == 1)
        begin
            gname = "edge_grant_o";
            cname = "edge";
        end
        // accepted when a command is out and the memory answers nonzero
        exp_grant = ((m_cmd[ch] != BUS_NONE) && (resp != 4'h0)) ? m_owner[ch] : '0;
        check_value(gname, 64'(dut_grant), 64'(exp_grant));
        load = (m_cmd[ch] == BUS_NONE) || (exp_grant != '0);
        for (int i = 0; i < PE_NUM; i++)
        begin
            masked[i] = pend[ch][i] && !exp_grant[i];
        end
        if (load)
        begin
            win = -1;
            for (int k = 0; k < PE_NUM; k++)
            begin
                idx = (m_ptr[ch] + k) % PE_NUM;
                if (win < 0 && masked[idx])
                begin
                    win = idx;
                end
            end
            if (win >= 0)
            begin
                m_cmd[ch]   = (ch == 0 && pe_we[win]) ? BUS_STORE : BUS_LOAD;
                m_addr[ch]  = pe_addr[ch][win];
                m_data[ch]  = 64'(pe_data[win]);
                m_owner[ch] = PE_NUM'(1 << win);
                m_ptr[ch]   = (win + 1) % PE_NUM;
            end
            else
            begin
                m_cmd[ch] = BUS_NONE;
            end
        end
        // granted pe drops its request at the next edge
        for (int i = 0; i < PE_NUM; i++)
        begin
            if (exp_grant[i])
            begin
                pend[ch][i] = 1'b0;
            end
            else if (pend[ch][i])
            begin
                age[ch][i]++;
                if (age[ch][i] > GRANT_TIMEOUT)
                begin
                    fail_plain($sformatf("%s request of PE %0d never got a grant", cname, i));
                end
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial
    begin
        int                   line_idx;
        int                   base;
        int                   cycles;
        logic [MEM_TAG_W-1:0] vresp_now;
        logic [MEM_TAG_W-1:0] eresp_now;
        reset_i     = 1'b1;
        vertex_req  = '0;
        edge_req    = '0;
        vertex_resp = '0;
        edge_resp   = '0;
        lfsr_q      = LFSR_SEED;
        for (int c = 0; c < 2; c++)
        begin
            for (int i = 0; i < PE_NUM; i++)
            begin
                pend[c][i]    = 1'b0;
                pe_addr[c][i] = '0;
                age[c][i]     = 0;
            end
            m_cmd[c]   = BUS_NONE;
            m_addr[c]  = '0;
            m_data[c]  = '0;
            m_owner[c] = '0;
            m_ptr[c]   = 0;
        end
        for (int i = 0; i < PE_NUM; i++)
        begin
            pe_we[i]   = 1'b0;
            pe_data[i] = '0;
        end
        $readmemh("bench/mem_input.txt", vec_mem);

        // idle bus and no grants all through reset
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge clock);
            if (i == RESET_CYCLES - 1)
            begin
                reset_i <= 1'b0;
            end
            @(negedge clock);
            check_value("vertexmem_cmd_o.command", 64'(vertex_cmd.command), 64'(BUS_NONE));
            check_value("edgemem_cmd_o.command", 64'(edge_cmd.command), 64'(BUS_NONE));
            check_value("vertex_grant_o", 64'(vertex_grant), 64'h0);
            check_value("edge_grant_o", 64'(edge_grant), 64'h0);
        end

        // drive on the rising edge, check at the falling edge
        line_idx = 0;
        while (line_idx < MAX_LINES && vec_mem[line_idx * NUM_FIELDS] != END_MARK)
        begin
            base = line_idx * NUM_FIELDS;
            @(posedge clock);
            add_requests(0, vec_mem[base], vec_mem[base + 1], vec_mem[base + 2],
                         vec_mem[base + 3]);
            add_requests(1, vec_mem[base + 4], 16'h0, vec_mem[base + 5], 16'h0);
            pick_response(vec_mem[base + 6], vresp_now);
            pick_response(vec_mem[base + 7], eresp_now);
            drive_inputs(vresp_now, eresp_now);
            @(negedge clock);
            check_outputs();
            if (vec_mem[base + 8] != 16'h0)
            begin
                check_value("vertex_grant_o", 64'(vertex_grant),
                            64'(vec_mem[base + 9][PE_NUM-1:0]));
                check_value("edge_grant_o", 64'(edge_grant),
                            64'(vec_mem[base + 10][PE_NUM-1:0]));
            end
            step_channel(0, vresp_now, vertex_grant);
            step_channel(1, eresp_now, edge_grant);
            line_idx++;
        end

        // memory always accepts until every pe is served
        cycles = 0;
        while (pending_count() != 0 && cycles < DRAIN_LIMIT)
        begin
            @(posedge clock);
            drive_inputs(4'h1, 4'h1);
            @(negedge clock);
            check_outputs();
            step_channel(0, 4'h1, vertex_grant);
            step_channel(1, 4'h1, edge_grant);
            cycles++;
        end
        if (pending_count() != 0)
        begin
            fail_plain("requests were still waiting for a grant after the drain limit");
        end
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== common/graphpulse_pkg.sv ====
`default_nettype none

package graphpulse_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------

    // processing elements sharing each memory
    localparam int PE_NUM = 4;
    // pe index width, log2 of PE_NUM
    localparam int PE_ID_W = 2;

    // memory bus address width
    localparam int XLEN = 16;

    // narrow addresses as the pes produce them
    localparam int VERTEX_ADDR_W = 8;
    localparam int EDGE_ADDR_W = 14;

    // vertex update value
    localparam int DELTA_W = 16;
    // store data bus
    localparam int MEM_DATA_W = 64;
    // memory response, 0 means stall, else tag
    localparam int MEM_TAG_W = 4;

    // ----------------------------------------
    // bus types
    // ----------------------------------------

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    // vertex request from one pe, loads and stores
    typedef struct packed {
        logic                     valid;
        logic                     we;
        logic [VERTEX_ADDR_W-1:0] addr;
        logic [DELTA_W-1:0]       wdata;
    } vertex_req_t;

    // edge request from one pe, loads only
    typedef struct packed {
        logic                   valid;
        logic [EDGE_ADDR_W-1:0] addr;
    } edge_req_t;

    // command towards vertex memory
    typedef struct packed {
        bus_command_t          command;
        logic [XLEN-1:0]       addr;
        logic [MEM_DATA_W-1:0] st_data;
    } vertex_cmd_t;

    // command towards edge memory, no store data
    typedef struct packed {
        bus_command_t    command;
        logic [XLEN-1:0] addr;
    } edge_cmd_t;

endpackage

`default_nettype wire

// ==== logic/graphpulse_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module graphpulse_mem_top (
    input  wire logic                                                     clock,
    input  wire logic                                                     reset_i,
    // per-pe request ports
    input  wire graphpulse_pkg::vertex_req_t [graphpulse_pkg::PE_NUM-1:0] vertex_req_i,
    input  wire graphpulse_pkg::edge_req_t [graphpulse_pkg::PE_NUM-1:0]   edge_req_i,
    // memory responses, 0 stalls the command
    input  wire logic [graphpulse_pkg::MEM_TAG_W-1:0]                     vertexmem_response_i,
    input  wire logic [graphpulse_pkg::MEM_TAG_W-1:0]                     edgemem_response_i,
    // memory commands
    output graphpulse_pkg::vertex_cmd_t                                   vertexmem_cmd_o,
    output graphpulse_pkg::edge_cmd_t                                     edgemem_cmd_o,
    // one-hot grant pulses back to the pes
    output logic [graphpulse_pkg::PE_NUM-1:0]                             vertex_grant_o,
    output logic [graphpulse_pkg::PE_NUM-1:0]                             edge_grant_o
);

    // ----------------------------------------
    // vertex memory path
    // ----------------------------------------

    // loads and stores of vertex values
    vertex_mem_ctrl i_vertex_mc (
        .clock      (clock),
        .reset_i    (reset_i),
        .req_i      (vertex_req_i),
        .response_i (vertexmem_response_i),
        .cmd_o      (vertexmem_cmd_o),
        .grant_o    (vertex_grant_o)
    );

    // ----------------------------------------
    // edge memory path
    // ----------------------------------------

    // read only edge list fetches
    // independent arbiter, own pointer
    edge_mem_ctrl i_edge_mc (
        .clock      (clock),
        .reset_i    (reset_i),
        .req_i      (edge_req_i),
        .response_i (edgemem_response_i),
        .cmd_o      (edgemem_cmd_o),
        .grant_o    (edge_grant_o)
    );

endmodule

`default_nettype wire

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
    input  wire logic                              clock,
    input  wire logic                              reset_i,
    input  wire logic [graphpulse_pkg::PE_NUM-1:0] req_i,
    input  wire logic                              advance_i,
    output logic      [graphpulse_pkg::PE_NUM-1:0] grant_o
);

    import graphpulse_pkg::*;

    // pe with highest priority this cycle
    logic [PE_ID_W-1:0] ptr_q;
    // candidate index while scanning
    logic [PE_ID_W-1:0] cand;
    // index of the chosen pe
    logic [PE_ID_W-1:0] win_idx;
    logic               found;

    // ----------------------------------------
    // priority scan
    // ----------------------------------------

    // walk from ptr_q upward, index wraps at PE_NUM
    always_comb
    begin
        found   = 1'b0;
        win_idx = ptr_q;
        cand    = ptr_q;
        grant_o = '0;
        for (int i = 0; i < PE_NUM; i++)
        begin
            cand = ptr_q + PE_ID_W'(i);
            // first requester after the pointer wins
            if (!found && req_i[cand])
            begin
                found   = 1'b1;
                win_idx = cand;
            end
        end
        if (found)
        begin
            grant_o[win_idx] = 1'b1;
        end
    end

    // ----------------------------------------
    // pointer update
    // ----------------------------------------

    // pe 0 first after reset
    always_ff @(posedge clock)
    begin
        if (reset_i)
        begin
            ptr_q <= '0;
        end
        // winner gets lowest priority next round
        else if (advance_i && found)
        begin
            ptr_q <= win_idx + PE_ID_W'(1);
        end
    end

endmodule

`default_nettype wire

// ==== mem_ctrl/edge_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_mem_ctrl (
    input  wire logic                                                   clock,
    input  wire logic                                                   reset_i,
    input  wire graphpulse_pkg::edge_req_t [graphpulse_pkg::PE_NUM-1:0] req_i,
    input  wire logic [graphpulse_pkg::MEM_TAG_W-1:0]                   response_i,
    output graphpulse_pkg::edge_cmd_t                                   cmd_o,
    output logic [graphpulse_pkg::PE_NUM-1:0]                           grant_o
);

    import graphpulse_pkg::*;

    // issue register, read only so no data
    bus_command_t      command_q;
    logic [XLEN-1:0]   addr_q;
    logic [PE_NUM-1:0] owner_q;

    logic              accept;
    logic              load_en;
    logic [PE_NUM-1:0] req_valid;
    logic [PE_NUM-1:0] masked_req;
    logic [PE_NUM-1:0] win;
    logic              have_req;
    edge_req_t         sel_req;

    // ----------------------------------------
    // accept and mask
    // ----------------------------------------

    assign accept  = (command_q != BUS_NONE) && (response_i != '0);
    assign load_en = (command_q == BUS_NONE) || accept;
    assign grant_o = accept ? owner_q : '0;

    always_comb
    begin
        for (int i = 0; i < PE_NUM; i++)
        begin
            req_valid[i] = req_i[i].valid;
        end
    end

    // drop the pe being granted right now
    assign masked_req = req_valid & ~grant_o;
    assign have_req   = |masked_req;

    rr_arbiter i_arb (
        .clock     (clock),
        .reset_i   (reset_i),
        .req_i     (masked_req),
        .advance_i (load_en),
        .grant_o   (win)
    );

    always_comb
    begin
        sel_req = '0;
        for (int i = 0; i < PE_NUM; i++)
        begin
            if (win[i])
            begin
                sel_req = req_i[i];
            end
        end
    end

    // ----------------------------------------
    // issue register
    // ----------------------------------------

    // always a load when something is waiting
    always_ff @(posedge clock)
    begin
        if (reset_i)
        begin
            command_q <= BUS_NONE;
        end
        else if (load_en)
        begin
            command_q <= have_req ? BUS_LOAD : BUS_NONE;
        end
    end

    // zero-extend edge address to bus width
    always_ff @(posedge clock)
    begin
        if (load_en && have_req)
        begin
            addr_q  <= {{(XLEN - EDGE_ADDR_W){1'b0}}, sel_req.addr};
            owner_q <= win;
        end
    end

    always_comb
    begin
        cmd_o.command = command_q;
        cmd_o.addr    = addr_q;
    end

endmodule

`default_nettype wire

// ==== mem_ctrl/vertex_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_mem_ctrl (
    input  wire logic                                          clock,
    input  wire logic                                          reset_i,
    input  wire graphpulse_pkg::vertex_req_t [graphpulse_pkg::PE_NUM-1:0] req_i,
    input  wire logic [graphpulse_pkg::MEM_TAG_W-1:0]          response_i,
    output graphpulse_pkg::vertex_cmd_t                        cmd_o,
    output logic [graphpulse_pkg::PE_NUM-1:0]                  grant_o
);

    import graphpulse_pkg::*;

    // issue register
    bus_command_t          command_q;
    logic [XLEN-1:0]       addr_q;
    logic [MEM_DATA_W-1:0] data_q;
    // one-hot owner of the issued command
    logic [PE_NUM-1:0]     owner_q;

    logic              accept;
    logic              load_en;
    logic [PE_NUM-1:0] req_valid;
    logic [PE_NUM-1:0] masked_req;
    logic [PE_NUM-1:0] win;
    logic              have_req;
    vertex_req_t       sel_req;

    // ----------------------------------------
    // accept and mask
    // ----------------------------------------

    // nonzero response takes the command
    assign accept  = (command_q != BUS_NONE) && (response_i != '0);
    // register free or emptying this edge
    assign load_en = (command_q == BUS_NONE) || accept;

    // grant pulse on the owner bit only
    assign grant_o = accept ? owner_q : '0;

    always_comb
    begin
        for (int i = 0; i < PE_NUM; i++)
        begin
            req_valid[i] = req_i[i].valid;
        end
    end

    // owner still holds its request during the accept cycle, skip it
    assign masked_req = req_valid & ~grant_o;
    assign have_req   = |masked_req;

    rr_arbiter i_arb (
        .clock     (clock),
        .reset_i   (reset_i),
        .req_i     (masked_req),
        .advance_i (load_en),
        .grant_o   (win)
    );

    // one-hot select of the winning request
    always_comb
    begin
        sel_req = '0;
        for (int i = 0; i < PE_NUM; i++)
        begin
            if (win[i])
            begin
                sel_req = req_i[i];
            end
        end
    end

    // ----------------------------------------
    // issue register
    // ----------------------------------------

    // command kind, cleared by reset
    always_ff @(posedge clock)
    begin
        if (reset_i)
        begin
            command_q <= BUS_NONE;
        end
        else if (load_en)
        begin
            if (have_req)
            begin
                command_q <= sel_req.we ? BUS_STORE : BUS_LOAD;
            end
            else
            begin
                command_q <= BUS_NONE;
            end
        end
    end

    // payload and owner, held under stall
    always_ff @(posedge clock)
    begin
        if (load_en && have_req)
        begin
            addr_q  <= {{(XLEN - VERTEX_ADDR_W){1'b0}}, sel_req.addr};
            data_q  <= {{(MEM_DATA_W - DELTA_W){1'b0}}, sel_req.wdata};
            owner_q <= win;
        end
    end

    always_comb
    begin
        cmd_o.command = command_q;
        cmd_o.addr    = addr_q;
        cmd_o.st_data = data_q;
    end

endmodule

`default_nettype wire
